/* cu_coalescer.sv */
// ------------------------------
// Event coalescer
// Pops both event FIFOs in pairs, merges
// pairs with equal keys into one event with
// a saturating sum, otherwise sends A then B.
// On flush drains the leftovers A first, then B
// ------------------------------
`timescale 1ns/1ps

module cu_coalescer (
    input  logic                     clk,
    input  logic                     rst,

    // FIFO status and pop requests
    input  logic                     empty_a_i,
    input  logic                     empty_b_i,
    output logic                     rd_a_o,
    output logic                     rd_b_o,

    // Popped events
    input  logic [cu_pkg::EVT_W-1:0] rdata_a_i,
    input  logic [cu_pkg::EVT_W-1:0] rdata_b_i,
    input  logic                     rvalid_a_i,
    input  logic                     rvalid_b_i,

    // Drain request
    input  logic                     flush_i,

    // Output events
    output logic                     out_valid_o,
    output logic [cu_pkg::KEY_W-1:0] out_key_o,
    output logic [cu_pkg::VAL_W-1:0] out_val_o,
    output logic                     out_merged_o,
    output logic                     flush_done_o
);

    import cu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PAIR,
        S_HOLD,
        S_FLA,
        S_FLB
    } state_t;

    state_t           state_q;
    state_t           state_d;

    logic             flush_pend_q;
    logic             done_arm_q;
    logic             done_arm_d;
    logic             flush_act;
    logic             pair_go;
    logic             flush_go;

    // Event fields of the two read ports
    logic [KEY_W-1:0] key_a;
    logic [KEY_W-1:0] key_b;
    logic [VAL_W-1:0] val_a;
    logic [VAL_W-1:0] val_b;
    logic             key_eq;
    logic [VAL_W:0]   sum;
    logic [VAL_W-1:0] sum_sat;

    // B event parked while A goes out
    logic [EVT_W-1:0] hold_q;

    // Next output
    logic             out_valid_d;
    logic             out_merged_d;
    logic [KEY_W-1:0] out_key_d;
    logic [VAL_W-1:0] out_val_d;

    // ------------------------------
    // Field decode and merge sum
    // ------------------------------
    assign key_a  = rdata_a_i[EVT_W-1 -: KEY_W];
    assign key_b  = rdata_b_i[EVT_W-1 -: KEY_W];
    assign val_a  = rdata_a_i[VAL_W-1:0];
    assign val_b  = rdata_b_i[VAL_W-1:0];
    assign key_eq = (key_a == key_b);

    // Carry out means overflow, clip to the limit
    assign sum     = {1'b0, val_a} + {1'b0, val_b};
    assign sum_sat = sum[VAL_W] ? VAL_MAX : sum[VAL_W-1:0];

    // ------------------------------
    // Pop control
    // ------------------------------

    // Pairs keep priority even under flush, so only true leftovers drain
    assign pair_go   = (state_q == S_IDLE) && !empty_a_i && !empty_b_i;
    assign flush_act = flush_i || flush_pend_q;
    assign flush_go  = (state_q == S_IDLE) && !pair_go && flush_act;

    assign rd_a_o = pair_go || ((state_q == S_FLA) && !empty_a_i);
    assign rd_b_o = pair_go || ((state_q == S_FLB) && !empty_b_i);

    // Next state
    always_comb begin
        state_d    = state_q;
        done_arm_d = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (pair_go) begin
                    state_d = S_PAIR;
                end else if (flush_go) begin
                    if (!empty_a_i) begin
                        state_d = S_FLA;
                    end else if (!empty_b_i) begin
                        state_d = S_FLB;
                    end
                end
            end
            // Pair returns this cycle
            S_PAIR: begin
                state_d = key_eq ? S_IDLE : S_HOLD;
            end
            S_HOLD: begin
                state_d = S_IDLE;
            end
            // Last pop seen once the FIFO reads empty
            S_FLA: begin
                if (empty_a_i) begin
                    if (!empty_b_i) begin
                        state_d = S_FLB;
                    end else begin
                        state_d    = S_IDLE;
                        done_arm_d = 1'b1;
                    end
                end
            end
            S_FLB: begin
                if (empty_b_i) begin
                    state_d    = S_IDLE;
                    done_arm_d = 1'b1;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    // ------------------------------
    // Output select
    // ------------------------------
    always_comb begin
        out_valid_d  = 1'b0;
        out_merged_d = 1'b0;
        out_key_d    = key_a;
        out_val_d    = val_a;
        case (state_q)
            S_PAIR: begin
                out_valid_d = rvalid_a_i && rvalid_b_i;
                if (key_eq) begin
                    out_merged_d = rvalid_a_i && rvalid_b_i;
                    out_val_d    = sum_sat;
                end
            end
            S_HOLD: begin
                out_valid_d = 1'b1;
                out_key_d   = hold_q[EVT_W-1 -: KEY_W];
                out_val_d   = hold_q[VAL_W-1:0];
            end
            S_FLA: begin
                out_valid_d = rvalid_a_i;
            end
            S_FLB: begin
                out_valid_d = rvalid_b_i;
                out_key_d   = key_b;
                out_val_d   = val_b;
            end
            default: ;
        endcase
    end

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= S_IDLE;
            flush_pend_q <= 1'b0;
            done_arm_q   <= 1'b0;
            out_valid_o  <= 1'b0;
            out_merged_o <= 1'b0;
            flush_done_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            done_arm_q   <= done_arm_d;
            out_valid_o  <= out_valid_d;
            out_merged_o <= out_merged_d;
            // Nothing left pulses at once, else after the last event
            flush_done_o <= done_arm_q || (flush_go && empty_a_i && empty_b_i);
            // Flush waits for the open pair, ignored while draining
            if (flush_go) begin
                flush_pend_q <= 1'b0;
            end else if (flush_i && (state_q != S_FLA) && (state_q != S_FLB)) begin
                flush_pend_q <= 1'b1;
            end
        end
    end

    // Payload only moves with a valid event
    always_ff @(posedge clk) begin
        if (out_valid_d) begin
            out_key_o <= out_key_d;
            out_val_o <= out_val_d;
        end
        if ((state_q == S_PAIR) && !key_eq) begin
            hold_q <= rdata_b_i;
        end
    end

endmodule

/* cu_coalescer_assert.sv */
// ------------------------------
// Coalescer protocol assertions
// Pop requests only against a non-empty FIFO,
// merged flag only with a valid event, and
// flush done never alongside an event
// ------------------------------
`timescale 1ns/1ps

module cu_coalescer_assert (
    input logic clk,
    input logic rst,
    input logic empty_a_i,
    input logic empty_b_i,
    input logic rd_a_o,
    input logic rd_b_o,
    input logic out_valid_o,
    input logic out_merged_o,
    input logic flush_done_o
);

    // No pop from an empty FIFO
    a_no_pop_empty_a: assert property (@(posedge clk) disable iff (rst)
        rd_a_o |-> !empty_a_i)
        else $error("pop of FIFO A while it is empty");

    a_no_pop_empty_b: assert property (@(posedge clk) disable iff (rst)
        rd_b_o |-> !empty_b_i)
        else $error("pop of FIFO B while it is empty");

    // Merged flag qualifies a valid event
    a_merged_valid: assert property (@(posedge clk) disable iff (rst)
        out_merged_o |-> out_valid_o)
        else $error("out_merged_o high without out_valid_o");

    // Done pulse stands alone
    a_done_alone: assert property (@(posedge clk) disable iff (rst)
        !(flush_done_o && out_valid_o))
        else $error("flush_done_o high together with out_valid_o");

endmodule

bind cu_coalescer cu_coalescer_assert u_assert (.*);

/* cu_fifo.sv */
// ------------------------------
// Event FIFO
// Circular buffer for one event stream with
// ready and empty flags, registered read data
// with a one-cycle valid strobe, and a
// saturating count of rejected pushes
// ------------------------------
`timescale 1ns/1ps

module cu_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,

    // Push side
    input  logic                     wr_en_i,
    input  logic [cu_pkg::EVT_W-1:0] wdata_i,
    output logic                     ready_o,

    // Pop side
    input  logic                     rd_en_i,
    output logic [cu_pkg::EVT_W-1:0] rdata_o,
    output logic                     rdata_valid_o,
    output logic                     empty_o,

    // Rejected pushes
    output logic [cu_pkg::CNT_W-1:0] drop_cnt_o
);

    import cu_pkg::*;

    // Pointer width and occupancy width
    localparam int IDX_W = $clog2(FIFO_DEPTH);
    localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

    logic [EVT_W-1:0] mem [FIFO_DEPTH];

    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [OCC_W-1:0] count_q;

    logic             push;
    logic             pop;
    logic             drop;

    // ------------------------------
    // Handshake
    // ------------------------------

    // Accepted push, accepted pop, rejected push
    assign push = wr_en_i && ready_o;
    assign pop  = rd_en_i && !empty_o;
    assign drop = wr_en_i && !ready_o;

    // Flags straight from the occupancy count
    assign ready_o = (count_q != OCC_W'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);

    // ------------------------------
    // Occupancy and pointers
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            // Push and pop together keep the count
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase

            // Tail advances on push, wraps at depth
            if (push) begin
                if (tail_q == IDX_W'(FIFO_DEPTH - 1)) begin
                    tail_q <= '0;
                end else begin
                    tail_q <= tail_q + 1'b1;
                end
            end

            // Head advances on pop
            if (pop) begin
                if (head_q == IDX_W'(FIFO_DEPTH - 1)) begin
                    head_q <= '0;
                end else begin
                    head_q <= head_q + 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // Storage and read port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail_q] <= wdata_i;
        end
        // Read word held until the next pop
        if (pop) begin
            rdata_o <= mem[head_q];
        end
    end

    // Valid strobe one cycle after the pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_valid_o <= 1'b0;
        end else begin
            rdata_valid_o <= pop;
        end
    end

    // ------------------------------
    // Drop counter
    // ------------------------------

    // Sticks at all ones
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drop_cnt_o <= '0;
        end else if (drop && (drop_cnt_o != {CNT_W{1'b1}})) begin
            drop_cnt_o <= drop_cnt_o + 1'b1;
        end
    end

endmodule

/* cu_pkg.sv */
// ------------------------------
// Event coalescing unit shared definitions
// Event field widths, packed event layout,
// saturation limit of merged values and
// width of the per-stream drop counters
// ------------------------------
package cu_pkg;

    // ------------------------------
    // Event fields
    // ------------------------------

    // Key of an event, compared between paired events
    localparam int KEY_W = 8;

    // Value carried by an event
    localparam int VAL_W = 16;

    // Packed event, key in the upper bits, value in the lower bits
    localparam int EVT_W = KEY_W + VAL_W;

    // ------------------------------
    // Merge arithmetic
    // ------------------------------

    // Largest value, a merged sum clips here
    localparam logic [VAL_W-1:0] VAL_MAX = {VAL_W{1'b1}};

    // ------------------------------
    // Status counters
    // ------------------------------

    // Drop counters saturate at all ones
    localparam int CNT_W = 16;

endpackage

/* cu_top.sv */
// ------------------------------
// Event coalescing unit top level
// Two event FIFOs side by side feeding
// one coalescer
// ------------------------------
`timescale 1ns/1ps

module cu_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,

    // Stream A
    input  logic                     push_a_i,
    input  logic [cu_pkg::KEY_W-1:0] key_a_i,
    input  logic [cu_pkg::VAL_W-1:0] val_a_i,
    output logic                     ready_a_o,

    // Stream B
    input  logic                     push_b_i,
    input  logic [cu_pkg::KEY_W-1:0] key_b_i,
    input  logic [cu_pkg::VAL_W-1:0] val_b_i,
    output logic                     ready_b_o,

    input  logic                     flush_i,

    // Coalesced events
    output logic                     out_valid_o,
    output logic [cu_pkg::KEY_W-1:0] out_key_o,
    output logic [cu_pkg::VAL_W-1:0] out_val_o,
    output logic                     out_merged_o,
    output logic                     flush_done_o,

    // Rejected pushes per stream
    output logic [cu_pkg::CNT_W-1:0] drop_a_o,
    output logic [cu_pkg::CNT_W-1:0] drop_b_o
);

    import cu_pkg::*;

    // FIFO to coalescer
    logic             empty_a;
    logic             empty_b;
    logic             rd_a;
    logic             rd_b;
    logic [EVT_W-1:0] rdata_a;
    logic [EVT_W-1:0] rdata_b;
    logic             rvalid_a;
    logic             rvalid_b;

    // ------------------------------
    // Event FIFOs
    // ------------------------------

    // Key packed above value
    cu_fifo #(
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_fifo_a (
        .clk           (clk),
        .rst           (rst),
        .wr_en_i       (push_a_i),
        .wdata_i       ({key_a_i, val_a_i}),
        .ready_o       (ready_a_o),
        .rd_en_i       (rd_a),
        .rdata_o       (rdata_a),
        .rdata_valid_o (rvalid_a),
        .empty_o       (empty_a),
        .drop_cnt_o    (drop_a_o)
    );

    cu_fifo #(
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_fifo_b (
        .clk           (clk),
        .rst           (rst),
        .wr_en_i       (push_b_i),
        .wdata_i       ({key_b_i, val_b_i}),
        .ready_o       (ready_b_o),
        .rd_en_i       (rd_b),
        .rdata_o       (rdata_b),
        .rdata_valid_o (rvalid_b),
        .empty_o       (empty_b),
        .drop_cnt_o    (drop_b_o)
    );

    // ------------------------------
    // Coalescer
    // ------------------------------
    cu_coalescer u_coal (
        .clk          (clk),
        .rst          (rst),
        .empty_a_i    (empty_a),
        .empty_b_i    (empty_b),
        .rd_a_o       (rd_a),
        .rd_b_o       (rd_b),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b),
        .rvalid_a_i   (rvalid_a),
        .rvalid_b_i   (rvalid_b),
        .flush_i      (flush_i),
        .out_valid_o  (out_valid_o),
        .out_key_o    (out_key_o),
        .out_val_o    (out_val_o),
        .out_merged_o (out_merged_o),
        .flush_done_o (flush_done_o)
    );

endmodule

/* tb.f */
cu_pkg.sv
cu_fifo.sv
cu_coalescer.sv
cu_top.sv
cu_coalescer_assert.sv
tb_clkgen.sv
tb_cu_top.sv

/* tb_clkgen.sv */
// ------------------------------
// Testbench clock and reset
// 20 ns clock, reset held for two cycles
// ------------------------------
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    // Half period of 10 ns
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Release just after an edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 rst_o = 1'b0;
    end

endmodule

/* tb_cu_top.sv */
// ------------------------------
// Event coalescing unit testbench
// Directed and random pushes on both streams,
// reference list of expected events per flush
// phase, drop counter checks and a watchdog
// ------------------------------
`timescale 1ns/1ps

module tb_cu_top;

    import cu_pkg::*;

    typedef struct packed {
        logic             merged;
        logic [KEY_W-1:0] key;
        logic [VAL_W-1:0] val;
    } evt_t;
    typedef evt_t evt_q_t [$];

    // Upper bound of pushes over all tests
    localparam int N_PUSH    = 8 + 8 + 7 + 11 + 4 * 30 * 2;
    localparam int CYC_LIMIT = 40 * N_PUSH + 200;

    logic clk, rst;
    logic push_a_i, push_b_i, flush_i;
    logic [KEY_W-1:0] key_a_i, key_b_i, out_key_o;
    logic [VAL_W-1:0] val_a_i, val_b_i, out_val_o;
    logic ready_a_o, ready_b_o, out_valid_o, out_merged_o, flush_done_o;
    logic [CNT_W-1:0] drop_a_o, drop_b_o;

    evt_q_t      qa, qb, got_q;
    int          cyc, done_cnt, done_cyc, last_out_cyc;
    int          err_cnt, pass_cnt, fail_cnt, exp_drop_a, exp_drop_b;
    logic [31:0] lcg_state;

    tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

    cu_top #(.FIFO_DEPTH(8)) uut (
        .clk(clk), .rst(rst),
        .push_a_i(push_a_i), .key_a_i(key_a_i), .val_a_i(val_a_i), .ready_a_o(ready_a_o),
        .push_b_i(push_b_i), .key_b_i(key_b_i), .val_b_i(val_b_i), .ready_b_o(ready_b_o),
        .flush_i(flush_i), .out_valid_o(out_valid_o), .out_key_o(out_key_o),
        .out_val_o(out_val_o), .out_merged_o(out_merged_o), .flush_done_o(flush_done_o),
        .drop_a_o(drop_a_o), .drop_b_o(drop_b_o)
    );

    // ------------------------------
    // Reference and helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected output list from the two push queues
    function automatic evt_q_t ref_coalesce(input evt_q_t a, input evt_q_t b);
        evt_q_t r;
        evt_t   e;
        int     n;
        int     s;
        n = (a.size() < b.size()) ? a.size() : b.size();
        for (int k = 0; k < n; k++) begin
            if (a[k].key == b[k].key) begin
                s        = int'(a[k].val) + int'(b[k].val);
                e.merged = 1'b1;
                e.key    = a[k].key;
                e.val    = (s > int'(VAL_MAX)) ? VAL_MAX : s[VAL_W-1:0];
                r.push_back(e);
            end else begin
                r.push_back(a[k]);
                r.push_back(b[k]);
            end
        end
        // Leftovers of A first, then of B
        for (int k = n; k < a.size(); k++) begin
            r.push_back(a[k]);
        end
        for (int k = n; k < b.size(); k++) begin
            r.push_back(b[k]);
        end
        return r;
    endfunction

    task automatic check_event(input int idx, input logic [KEY_W-1:0] gk,
                               input logic [VAL_W-1:0] gv, input logic gm,
                               input logic [KEY_W-1:0] ek, input logic [VAL_W-1:0] ev,
                               input logic em);
        if (gk !== ek || gv !== ev || gm !== em) begin
            $display("MISMATCH @%0t: event %0d got key %h val %h merged %b, exp %h %h %b",
                     $time, idx, gk, gv, gm, ek, ev, em);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got %0d, exp %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // One cycle of stimulus 2 ns after the edge
    // Ready here already holds its value for the next edge
    task automatic drive(input logic pa, input logic [KEY_W-1:0] ka,
                         input logic [VAL_W-1:0] va, input logic pb,
                         input logic [KEY_W-1:0] kb, input logic [VAL_W-1:0] vb);
        @(posedge clk);
        #2;
        push_a_i = pa;
        key_a_i  = ka;
        val_a_i  = va;
        push_b_i = pb;
        key_b_i  = kb;
        val_b_i  = vb;
        if (pa && ready_a_o) qa.push_back({1'b0, ka, va});
        if (pa && !ready_a_o) exp_drop_a++;
        if (pb && ready_b_o) qb.push_back({1'b0, kb, vb});
        if (pb && !ready_b_o) exp_drop_b++;
    endtask

    // Flush and compare the phase against the reference
    task automatic flush_and_check();
        evt_q_t exp;
        int     d0;
        d0 = done_cnt;
        @(posedge clk);
        #2;
        push_a_i = 1'b0;
        push_b_i = 1'b0;
        flush_i  = 1'b1;
        @(posedge clk);
        #2 flush_i = 1'b0;
        while (done_cnt == d0) @(posedge clk);
        repeat (4) @(posedge clk);
        if (done_cnt != d0 + 1) begin
            $display("flush_done_o pulsed %0d times for one flush", done_cnt - d0);
            err_cnt++;
        end
        if (got_q.size() > 0 && done_cyc <= last_out_cyc) begin
            $display("flush_done_o came before the last drained event");
            err_cnt++;
        end
        exp = ref_coalesce(qa, qb);
        if (got_q.size() != exp.size()) begin
            $display("MISMATCH @%0t: %0d events out, exp %0d", $time, got_q.size(), exp.size());
            err_cnt++;
        end
        for (int i = 0; i < got_q.size() && i < exp.size(); i++) begin
            check_event(i, got_q[i].key, got_q[i].val, got_q[i].merged,
                        exp[i].key, exp[i].val, exp[i].merged);
        end
        qa.delete();
        qb.delete();
        got_q.delete();
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        if (err_cnt == err_start) begin
            pass_cnt++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: FAIL (%0d errors)", num, name, err_cnt - err_start);
        end
    endtask

    // ------------------------------
    // Monitor and watchdog
    // ------------------------------

    // Registered outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid_o) begin
                got_q.push_back({out_merged_o, out_key_o, out_val_o});
                last_out_cyc = cyc;
            end
            if (flush_done_o) begin
                done_cnt++;
                done_cyc = cyc;
            end
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= CYC_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int          e0;
        logic [31:0] ra;
        logic [31:0] rb;
        push_a_i     = 1'b0;
        key_a_i      = '0;
        val_a_i      = '0;
        push_b_i     = 1'b0;
        key_b_i      = '0;
        val_b_i      = '0;
        flush_i      = 1'b0;
        cyc          = 0;
        done_cnt     = 0;
        done_cyc     = 0;
        last_out_cyc = 0;
        err_cnt      = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        exp_drop_a   = 0;
        exp_drop_b   = 0;
        lcg_state    = 32'h2915;
        @(negedge rst);
        @(posedge clk);
        #2;
        if (!ready_a_o || !ready_b_o || out_valid_o || out_merged_o || flush_done_o) begin
            $display("Outputs not in their reset state after reset");
            err_cnt++;
        end

        // Equal keys with two overflowing sums
        e0 = err_cnt;
        drive(1, 8'h03, 16'd100, 1, 8'h03, 16'd200);
        drive(1, 8'h07, 16'hF000, 1, 8'h07, 16'h2000);
        drive(1, 8'h00, 16'hFFFF, 1, 8'h00, 16'h0001);
        drive(1, 8'h55, 16'd1, 1, 8'h55, 16'd2);
        flush_and_check();
        report_test(1, "merge of equal keys", e0);

        // Different keys give A then B
        e0 = err_cnt;
        for (int i = 0; i < 4; i++) begin
            drive(1, 8'(i + 1), 16'(16'h0A00 + i), 1, 8'(9 - i), 16'(16'h0B00 + i));
        end
        flush_and_check();
        report_test(2, "serialize of different keys", e0);

        // Five A against two B and an empty flush
        e0 = err_cnt;
        for (int i = 0; i < 5; i++) begin
            drive(1, 8'(16 + i), 16'(i * 3), i < 2, 8'(16 + i), 16'(i * 7));
        end
        flush_and_check();
        flush_and_check();
        report_test(3, "flush of leftovers", e0);

        // Eleven pushes into A with B empty
        e0 = err_cnt;
        for (int i = 0; i < 11; i++) begin
            drive(1, 8'(32 + i), 16'(i), 0, '0, '0);
        end
        // Last push lands on this edge
        @(posedge clk);
        #2;
        push_a_i = 1'b0;
        if (ready_a_o) begin
            $display("ready_a_o stayed high with FIFO A full");
            err_cnt++;
        end
        if (got_q.size() != 0) begin
            $display("Events came out while FIFO B was empty");
            err_cnt++;
        end
        check_count("drop_a_o", drop_a_o, 16'(exp_drop_a));
        check_count("drop count A expected", 16'(exp_drop_a), 16'd3);
        check_count("drop_b_o", drop_b_o, '0);
        flush_and_check();
        report_test(4, "drops on full FIFO", e0);

        // Random phases with skewed push rates and four keys
        e0 = err_cnt;
        for (int p = 0; p < 4; p++) begin
            for (int c = 0; c < 30; c++) begin
                lcg_state = lcg_next(lcg_state);
                ra        = lcg_state;
                lcg_state = lcg_next(lcg_state);
                rb        = lcg_state;
                drive(p[0] ? (ra[2:0] != 0) : (ra[1:0] == 0), {6'd0, ra[9:8]},
                      ra[31:16] | (p[1] ? 16'hC000 : 16'h0),
                      p[0] ? (rb[1:0] == 0) : (rb[2:0] != 0), {6'd0, rb[9:8]},
                      rb[31:16] | (p[1] ? 16'hC000 : 16'h0));
            end
            flush_and_check();
        end
        check_count("drop_a_o", drop_a_o, 16'(exp_drop_a));
        check_count("drop_b_o", drop_b_o, 16'(exp_drop_b));
        report_test(5, "random run", e0);

        $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
